// ==== include/fft_defines.svh ====
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

// Points per frame
`define FFT_N 8

// Real or imaginary part of one input sample
`define SAMPLE_W 12

// Signed twiddle coefficient, unity is 1 << TW_SHIFT
`define COEFF_W 11

// Each part of a stage result
`define OUT_W (`SAMPLE_W + `COEFF_W + 1)

// Twiddle scale exponent
`define TW_SHIFT 9

`endif

// ==== source/fft_types_pkg.sv ====
`include "fft_defines.svh"

package fft_types_pkg;

  // One complex input sample, re in the upper half
  typedef struct packed {
    logic signed [`SAMPLE_W-1:0] re;
    logic signed [`SAMPLE_W-1:0] im;
  } cplx_sample_t;

  // Input word as it arrives on the bus, or split into its parts
  typedef union packed {
    logic [2*`SAMPLE_W-1:0] raw;
    cplx_sample_t           cplx;
  } sample_word_u;

  // Stage output, scaled by the twiddle unity
  typedef struct packed {
    logic signed [`OUT_W-1:0] re;
    logic signed [`OUT_W-1:0] im;
  } cplx_result_t;

endpackage

// ==== source/fft_twiddle_pkg.sv ====
package fft_twiddle_pkg;

  // Rotation of one lane, encoded as the power of W8
  typedef enum logic [1:0] {
    TW_UNITY      = 2'd0,  // (512, 0)
    TW_DIAG_NEG   = 2'd1,  // (362, -363)
    TW_MINUS_J    = 2'd2,  // (0, -512)
    TW_DIAG_NEG_J = 2'd3   // (-363, -362)
  } twiddle_kind_t;

  // One signed power of two
  typedef struct packed {
    logic       neg;
    logic [3:0] shift;
  } csd_term_t;

  typedef csd_term_t [0:4] csd_table_t;

  // 2^9 - 2^7 - 2^5 + 2^3 + 2^1
  localparam csd_table_t CSD_P362 = '{'{1'b0, 4'd9}, '{1'b1, 4'd7}, '{1'b1, 4'd5},
                                      '{1'b0, 4'd3}, '{1'b0, 4'd1}};
  // -2^9 + 2^7 + 2^4 + 2^2 + 2^0
  localparam csd_table_t CSD_N363 = '{'{1'b1, 4'd9}, '{1'b0, 4'd7}, '{1'b0, 4'd4},
                                      '{1'b0, 4'd2}, '{1'b0, 4'd0}};
  // -2^9 + 2^7 + 2^5 - 2^3 - 2^1
  localparam csd_table_t CSD_N362 = '{'{1'b1, 4'd9}, '{1'b0, 4'd7}, '{1'b0, 4'd5},
                                      '{1'b1, 4'd3}, '{1'b1, 4'd1}};

  // Lane k of the first DIF stage rotates by W8^k
  function automatic twiddle_kind_t lane_twiddle(input int lane);
    return twiddle_kind_t'(lane % 4);
  endfunction

  // Real coefficient terms, only meaningful for the diagonal kinds
  function automatic csd_table_t cr_terms(input twiddle_kind_t kind);
    case (kind)
      TW_DIAG_NEG:   return CSD_P362;
      TW_DIAG_NEG_J: return CSD_N363;
      default:       return '0;
    endcase
  endfunction

  // Imaginary coefficient terms
  function automatic csd_table_t ci_terms(input twiddle_kind_t kind);
    case (kind)
      TW_DIAG_NEG:   return CSD_N363;
      TW_DIAG_NEG_J: return CSD_N362;
      default:       return '0;
    endcase
  endfunction

endpackage

// ==== source/frame_collector.sv ====
`include "fft_defines.svh"

module frame_collector (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       in_valid,
  input  fft_types_pkg::sample_word_u                in_sample,
  output logic                                       frame_valid,
  output fft_types_pkg::cplx_sample_t [`FFT_N/2-1:0] upper,
  output fft_types_pkg::cplx_sample_t [`FFT_N/2-1:0] lower
);
  import fft_types_pkg::*;

  localparam int LANES = `FFT_N / 2;
  localparam int CNT_W = $clog2(`FFT_N);

  logic [CNT_W-1:0]         sample_cnt;  // Index of the next sample in the frame
  logic                     last_sample;
  cplx_sample_t             cur;
  cplx_sample_t [LANES-1:0] upper_buf;   // Samples 0 to 3
  cplx_sample_t [LANES-2:0] lower_buf;   // Samples 4 to 6

  assign cur         = in_sample.cplx;
  assign last_sample = in_valid && (sample_cnt == CNT_W'(`FFT_N - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_cnt  <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= last_sample;
      if (in_valid) begin
        sample_cnt <= sample_cnt + 1'b1;  // Wraps to the next frame
      end
    end
  end

  // Holding buffers
  always_ff @(posedge clk) begin
    if (in_valid && !sample_cnt[CNT_W-1]) begin
      upper_buf[sample_cnt[CNT_W-2:0]] <= cur;
    end else if (in_valid && !last_sample) begin
      lower_buf[sample_cnt[CNT_W-2:0]] <= cur;
    end
  end

  // Whole frame moves out at once so the next one can fill behind it
  always_ff @(posedge clk) begin
    if (last_sample) begin
      upper <= upper_buf;
      for (int i = 0; i < LANES - 1; i++) begin
        lower[i] <= lower_buf[i];
      end
      lower[LANES-1] <= cur;  // Eighth sample pairs with sample 3
    end
  end

endmodule

// ==== source/csd_twiddle_mult.sv ====
`include "fft_defines.svh"

module csd_twiddle_mult #(
  parameter fft_twiddle_pkg::twiddle_kind_t KIND = fft_twiddle_pkg::TW_UNITY
) (
  input  logic signed [`SAMPLE_W:0]  diff_re,
  input  logic signed [`SAMPLE_W:0]  diff_im,
  output logic signed [`OUT_W-1:0]   prod_re,
  output logic signed [`OUT_W-1:0]   prod_im
);
  import fft_twiddle_pkg::*;

  // Sum of signed shifted copies of value
  function automatic logic signed [`OUT_W-1:0] csd_product(
    input logic signed [`SAMPLE_W:0] value,
    input csd_table_t                terms
  );
    logic signed [`OUT_W-1:0] acc;
    logic signed [`OUT_W-1:0] term;
    acc = '0;
    for (int i = 0; i < 5; i++) begin
      term = value <<< terms[i].shift;
      if (terms[i].neg) begin
        acc = acc - term;
      end else begin
        acc = acc + term;
      end
    end
    return acc;
  endfunction

  if (KIND == TW_UNITY) begin : g_unity
    // W^0 is a plain scale
    assign prod_re = diff_re <<< `TW_SHIFT;
    assign prod_im = diff_im <<< `TW_SHIFT;

  end else if (KIND == TW_MINUS_J) begin : g_minus_j
    // (a + jb)(-j) = b - ja
    assign prod_re = diff_im <<< `TW_SHIFT;
    assign prod_im = -(diff_re <<< `TW_SHIFT);

  end else begin : g_csd
    localparam csd_table_t CR_TERMS = cr_terms(KIND);
    localparam csd_table_t CI_TERMS = ci_terms(KIND);

    logic signed [`OUT_W-1:0] pp_re_cr;
    logic signed [`OUT_W-1:0] pp_im_ci;
    logic signed [`OUT_W-1:0] pp_re_ci;
    logic signed [`OUT_W-1:0] pp_im_cr;

    assign pp_re_cr = csd_product(diff_re, CR_TERMS);
    assign pp_im_ci = csd_product(diff_im, CI_TERMS);
    assign pp_re_ci = csd_product(diff_re, CI_TERMS);
    assign pp_im_cr = csd_product(diff_im, CR_TERMS);

    assign prod_re = pp_re_cr - pp_im_ci;  // Real
    assign prod_im = pp_re_ci + pp_im_cr;  // Imag
  end

endmodule

// ==== source/butterfly_lane.sv ====
`include "fft_defines.svh"

module butterfly_lane #(
  parameter int LANE = 0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        frame_valid,
  input  fft_types_pkg::cplx_sample_t upper,
  input  fft_types_pkg::cplx_sample_t lower,
  output logic                        lane_valid,
  output fft_types_pkg::cplx_result_t sum_result,
  output fft_types_pkg::cplx_result_t diff_result
);
  import fft_types_pkg::*;
  import fft_twiddle_pkg::*;

  localparam twiddle_kind_t KIND = lane_twiddle(LANE);

  // One extra bit so neither sum nor difference can wrap
  logic signed [`SAMPLE_W:0] sum_re;
  logic signed [`SAMPLE_W:0] sum_im;
  logic signed [`SAMPLE_W:0] diff_re;
  logic signed [`SAMPLE_W:0] diff_im;
  cplx_result_t              sum_scaled;
  cplx_result_t              diff_rot;

  assign sum_re  = upper.re + lower.re;
  assign sum_im  = upper.im + lower.im;
  assign diff_re = upper.re - lower.re;
  assign diff_im = upper.im - lower.im;

  // Same scale as the twiddle products
  assign sum_scaled.re = sum_re <<< `TW_SHIFT;
  assign sum_scaled.im = sum_im <<< `TW_SHIFT;

  csd_twiddle_mult #(
    .KIND (KIND)
  ) u_mult (
    .diff_re (diff_re),
    .diff_im (diff_im),
    .prod_re (diff_rot.re),
    .prod_im (diff_rot.im)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_valid <= 1'b0;
    end else begin
      lane_valid <= frame_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (frame_valid) begin
      sum_result  <= sum_scaled;
      diff_result <= diff_rot;
    end
  end

endmodule

// ==== source/result_serializer.sv ====
`include "fft_defines.svh"

module result_serializer (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic [`FFT_N/2-1:0]                        lane_valid,
  input  fft_types_pkg::cplx_result_t [`FFT_N/2-1:0] sum_result,
  input  fft_types_pkg::cplx_result_t [`FFT_N/2-1:0] diff_result,
  output logic                                       out_valid,
  output fft_types_pkg::cplx_result_t                out_result
);
  import fft_types_pkg::*;

  localparam int LANES = `FFT_N / 2;
  localparam int CNT_W = $clog2(`FFT_N + 1);

  logic [CNT_W-1:0]          remain;     // Outputs still to present
  logic                      load;
  cplx_result_t [`FFT_N-2:0] shift_buf;  // Entry 0 goes out next

  // Lanes fire together
  assign load      = &lane_valid;
  assign out_valid = (remain != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remain <= '0;
    end else if (load) begin
      remain <= CNT_W'(`FFT_N);
    end else if (out_valid) begin
      remain <= remain - 1'b1;
    end
  end

  // Sums first, then the rotated differences
  always_ff @(posedge clk) begin
    if (load) begin
      out_result <= sum_result[0];
      for (int i = 1; i < LANES; i++) begin
        shift_buf[i-1] <= sum_result[i];
      end
      for (int i = 0; i < LANES; i++) begin
        shift_buf[LANES-1+i] <= diff_result[i];
      end
    end else if (out_valid) begin
      out_result <= shift_buf[0];
      for (int i = 0; i < `FFT_N - 2; i++) begin
        shift_buf[i] <= shift_buf[i+1];
      end
    end
  end

endmodule

// ==== source/fft_stage_top.sv ====
`include "fft_defines.svh"

module fft_stage_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  logic [2*`SAMPLE_W-1:0]  in_sample,
  output logic                    out_valid,
  output logic [2*`OUT_W-1:0]     out_result
);
  import fft_types_pkg::*;

  localparam int LANES = `FFT_N / 2;

  sample_word_u              in_word;
  logic                      frame_valid;
  cplx_sample_t [LANES-1:0]  upper;        // x[k]
  cplx_sample_t [LANES-1:0]  lower;        // x[k+4]
  logic [LANES-1:0]          lane_valid;
  cplx_result_t [LANES-1:0]  sum_result;
  cplx_result_t [LANES-1:0]  diff_result;

  assign in_word.raw = in_sample;

  frame_collector u_collector (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_sample   (in_word),
    .frame_valid (frame_valid),
    .upper       (upper),
    .lower       (lower)
  );

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    butterfly_lane #(
      .LANE (g)
    ) u_lane (
      .clk         (clk),
      .rst_n       (rst_n),
      .frame_valid (frame_valid),
      .upper       (upper[g]),
      .lower       (lower[g]),
      .lane_valid  (lane_valid[g]),
      .sum_result  (sum_result[g]),
      .diff_result (diff_result[g])
    );
  end

  result_serializer u_serializer (
    .clk         (clk),
    .rst_n       (rst_n),
    .lane_valid  (lane_valid),
    .sum_result  (sum_result),
    .diff_result (diff_result),
    .out_valid   (out_valid),
    .out_result  (out_result)
  );

endmodule

// ==== test/fft_stage_assertions.sv ====
`include "fft_defines.svh"

module fft_stage_assertions (
  input logic clk,
  input logic rst_n,
  input logic frame_valid,
  input logic out_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int POS_W = $clog2(`FFT_N);

  logic [POS_W-1:0] run_pos;  // High cycles of out_valid modulo one frame

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_pos <= '0;
    end else if (out_valid) begin
      run_pos <= run_pos + 1'b1;
    end
  end

  frame_valid_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    frame_valid |=> !frame_valid
  ) else $error("frame_valid stayed high for more than one cycle");

  // At least one whole frame after each rise
  out_valid_full_run: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(out_valid) |-> ##(`FFT_N - 1) out_valid
  ) else $error("out_valid fell before eight outputs");

  // Back-to-back frames keep it high, but only whole frames
  out_valid_whole_frames: assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(out_valid) |-> (run_pos == '0)
  ) else $error("out_valid fell in the middle of a frame");

  out_valid_in_reset: assert property (
    @(posedge clk)
    !rst_n |-> !out_valid
  ) else $error("out_valid high during reset");

endmodule

// ==== test/tb_fft_stage.sv ====
`include "fft_defines.svh"

module tb_fft_stage;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int     SEED        = 32'h49ca;
  localparam int     LANES       = `FFT_N / 2;
  localparam int     N_RANDOM    = 20;
  localparam int     N_BACK      = 6;
  localparam int     N_EXTREME   = 5;
  localparam int     N_FRAMES    = 1 + N_RANDOM + N_BACK + N_EXTREME;
  localparam int     CYCLE_LIMIT = N_FRAMES * `FFT_N * 2 + 100;
  localparam int     UNITY       = 1 << `TW_SHIFT;
  localparam int     MAX_PART    = (1 << (`SAMPLE_W - 1)) - 1;
  localparam int     MIN_PART    = -(1 << (`SAMPLE_W - 1));
  localparam longint PART_MAX    = (longint'(1) << (`OUT_W - 1)) - 1;

  // W8^k for lane k, real and imaginary coefficient
  localparam int COEF_RE [LANES] = '{512, 362, 0, -363};
  localparam int COEF_IM [LANES] = '{0, -363, -512, -362};

  logic                   clk;
  logic                   rst_n;
  logic                   in_valid;
  logic [2*`SAMPLE_W-1:0] in_sample;
  logic                   out_valid;
  logic [2*`OUT_W-1:0]    out_result;

  logic [2*`OUT_W-1:0] exp_q [$];
  logic [2*`OUT_W-1:0] exp_word;
  int                  start_q [$];  // Cycle at which each frame's first output is due
  int                  frame_re [`FFT_N];
  int                  frame_im [`FFT_N];
  int                  frame_n = 0;
  int                  cycle   = 0;
  int                  errors  = 0;
  int                  checked = 0;
  int                  seen    = 0;
  int                  out_pos = 0;  // Position within the current output frame
  int                  due;

  fft_stage_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  bind fft_stage_top fft_stage_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .out_valid   (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Truncate to a result part, complaining if it would not fit
  function automatic logic [`OUT_W-1:0] fit_part(input longint value);
    if (value > PART_MAX || value < -PART_MAX - 1) begin
      $display("Reference value %0d does not fit in %0d bits", value, `OUT_W);
      errors++;
    end
    return value[`OUT_W-1:0];
  endfunction

  // Expected outputs of one frame in stage order
  function automatic void expect_frame(input int re [`FFT_N], input int im [`FFT_N]);
    longint d_re;
    longint d_im;
    for (int k = 0; k < LANES; k++) begin
      exp_q.push_back({fit_part(longint'(re[k] + re[k+LANES]) * UNITY),
                       fit_part(longint'(im[k] + im[k+LANES]) * UNITY)});
    end
    for (int k = 0; k < LANES; k++) begin
      d_re = re[k] - re[k+LANES];
      d_im = im[k] - im[k+LANES];
      exp_q.push_back({fit_part(d_re * COEF_RE[k] - d_im * COEF_IM[k]),
                       fit_part(d_re * COEF_IM[k] + d_im * COEF_RE[k])});
    end
  endfunction

  function automatic int rand_part();
    return int'($urandom_range(2 * MAX_PART + 1, 0)) + MIN_PART;
  endfunction

  task automatic idle(input int n);
    in_valid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // Accepted on the next rising edge
  task automatic send_sample(input int re, input int im);
    in_valid  = 1'b1;
    in_sample = {re[`SAMPLE_W-1:0], im[`SAMPLE_W-1:0]};
    frame_re[frame_n] = re;
    frame_im[frame_n] = im;
    frame_n++;
    if (frame_n == `FFT_N) begin
      expect_frame(frame_re, frame_im);
      start_q.push_back(cycle + 3);  // Edge E is cycle+1, output 0 follows E+2
      frame_n = 0;
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic send_random_frame(input bit gaps);
    for (int i = 0; i < `FFT_N; i++) begin
      if (gaps && $urandom_range(2, 0) == 0) begin
        idle(1);
      end
      send_sample(rand_part(), rand_part());
    end
  endtask

  task automatic send_extreme_frame(input int kind);
    int re;
    int im;
    for (int n = 0; n < `FFT_N; n++) begin
      case (kind)
        0: begin re = MAX_PART; im = MAX_PART; end
        1: begin re = MIN_PART; im = MIN_PART; end
        2: begin re = (n < LANES) ? MAX_PART : MIN_PART; im = re; end
        3: begin
          re = (n < LANES) ? MAX_PART : MIN_PART;
          im = (n < LANES) ? MIN_PART : MAX_PART;
        end
        default: begin  // Alternating signs
          re = n[0] ? MIN_PART : MAX_PART;
          im = n[0] ? MAX_PART : MIN_PART;
        end
      endcase
      send_sample(re, im);
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      seen++;
      if (out_pos == 0) begin
        if (start_q.size() == 0) begin
          $display("A frame of outputs started with no frame pending at %0t", $time);
          errors++;
        end else begin
          due = start_q.pop_front();
          if (cycle != due) begin
            $display("Fail at %0t: frame started at cycle %0d, expected cycle %0d",
                     $time, cycle, due);
            errors++;
          end
        end
      end
      if (exp_q.size() == 0) begin
        $display("An output arrived while no result was expected at %0t", $time);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        checked++;
        if (out_result !== exp_word) begin
          $display("Fail at %0t: output %0d got %h expected %h",
                   $time, out_pos, out_result, exp_word);
          errors++;
        end
      end
      out_pos = (out_pos + 1) % `FFT_N;
    end else if (rst_n && out_pos != 0) begin
      $display("Fail at %0t: out_valid dropped after %0d outputs of a frame", $time, out_pos);
      errors++;
      out_pos = 0;
    end
  end

  initial begin
    void'($urandom(SEED));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_sample = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Seven samples alone must not start a frame
    for (int i = 0; i < `FFT_N - 1; i++) begin
      send_sample(rand_part(), rand_part());
    end
    idle(20);
    if (seen != 0) begin
      $display("Outputs appeared after only seven samples");
      errors++;
    end
    send_sample(rand_part(), rand_part());

    for (int f = 0; f < N_RANDOM; f++) begin
      send_random_frame(1'b1);
    end
    idle(12);
    for (int f = 0; f < N_BACK; f++) begin
      send_random_frame(1'b0);
    end
    for (int f = 0; f < N_EXTREME; f++) begin
      send_extreme_frame(f);
    end

    for (int i = 0; i < 30 && (exp_q.size() != 0 || out_valid); i++) begin
      @(negedge clk);
    end
    idle(4);

    if (exp_q.size() != 0) begin
      $display("%0d expected outputs never appeared", exp_q.size());
      errors++;
    end
    $display("Errors: %0d, outputs checked: %0d", errors, checked);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
source/fft_types_pkg.sv
source/fft_twiddle_pkg.sv
source/frame_collector.sv
source/csd_twiddle_mult.sv
source/butterfly_lane.sv
source/result_serializer.sv
source/fft_stage_top.sv
test/fft_stage_assertions.sv
test/tb_fft_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the FFT stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f src.f --top-module tb_fft_stage -Mdir obj_dir \
  || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vtb_fft_stage)
echo "$sim_out"

echo "$sim_out" | grep -q "Simulation PASSED" && exit 0 || exit 1
